// ==== source/router_pkg.sv ====
package router_pkg;

    // ****************************************
    // Port numbering
    // ****************************************
    localparam int NUM_PORTS = 5;

    typedef logic [2:0] port_idx_t;   // Port number, grant and route target
    typedef logic [5:0] addr_t;       // {group, node}
    typedef logic [3:0] group_t;
    typedef logic [1:0] node_t;

    localparam port_idx_t PORT_GPU    = 3'd0;
    localparam port_idx_t PORT_SPINE1 = 3'd1;
    localparam port_idx_t PORT_SPINE2 = 3'd2;
    localparam port_idx_t PORT_SPINE3 = 3'd3;
    localparam port_idx_t PORT_SPINE4 = 3'd4;

    // ****************************************
    // Status and control encodings
    // ****************************************
    typedef enum logic [1:0] {
        DIR_NONE    = 2'd0,
        DIR_UP      = 2'd1,   // GPU to spine
        DIR_DOWN    = 2'd2,   // Spine to GPU
        DIR_TRANSIT = 2'd3    // Spine to spine
    } dir_e;

    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_XFER = 2'd1,
        ARB_HOLD = 2'd2
    } arb_state_e;

endpackage

// ==== source/port_fifo.sv ====
`timescale 1ns/1ns

module port_fifo
    import router_pkg::*;
#(
    parameter int DWIDTH     = 16,
    parameter int FIFO_DEPTH = 8
)(
    input  logic              clk,
    input  logic              rst,
    input  logic [DWIDTH-1:0] in_data,
    input  logic              in_valid,
    input  addr_t             dest_addr,
    output logic              in_ready,
    input  logic              pop,
    output logic [DWIDTH-1:0] head_data,
    output addr_t             head_addr,
    output logic              empty,
    output logic              full
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [DWIDTH-1:0] data_mem [FIFO_DEPTH];
    addr_t             addr_mem [FIFO_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              wr_en;
    logic              rd_en;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
            return '0;   // Wrap for any depth
        end
        return ptr + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(FIFO_DEPTH));
    assign empty     = (count == '0);
    assign in_ready  = !full;
    assign wr_en     = in_valid && !full;
    assign rd_en     = pop && !empty;

    assign head_data = data_mem[rd_ptr];
    assign head_addr = addr_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            data_mem[wr_ptr] <= in_data;
            addr_mem[wr_ptr] <= dest_addr;   // Address rides with its word
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Idle or simultaneous push and pop
            endcase
        end
    end

    // Arbiter only pops a FIFO that holds a word
    assert property (@(posedge clk) disable iff (rst) pop |-> !empty)
        else $error("port_fifo: pop while empty");

    assert property (@(posedge clk) disable iff (rst)
        full && !pop |=> full && $stable(wr_ptr))
        else $error("port_fifo: write accepted while full");

endmodule

// ==== source/route_decoder.sv ====
`timescale 1ns/1ns

module route_decoder
    import router_pkg::*;
#(
    parameter int GROUP_ID  = 4'b0100,
    parameter int ROUTER_ID = 3
)(
    input  addr_t     head_addr,
    output port_idx_t target
);

    group_t addr_group;
    node_t  addr_node;
    logic   group_hit;
    logic   node_hit;
    logic   local_hit;

    assign addr_group = head_addr[5:2];
    assign addr_node  = head_addr[1:0];

    assign group_hit  = (addr_group == group_t'(GROUP_ID));
    assign node_hit   = (addr_node == node_t'(ROUTER_ID));
    assign local_hit  = group_hit && node_hit;   // Addressed to this GPU

    // Everything not local leaves on the spine chosen by the node field
    assign target = local_hit ? PORT_GPU : PORT_SPINE1 + port_idx_t'(addr_node);

endmodule

// ==== source/crossbar_arbiter.sv ====
`timescale 1ns/1ns

module crossbar_arbiter
    import router_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 arb_enable,
    input  logic [NUM_PORTS-1:0] not_empty,
    input  port_idx_t            target_0,
    input  port_idx_t            target_1,
    input  port_idx_t            target_2,
    input  port_idx_t            target_3,
    input  port_idx_t            target_4,
    input  logic [NUM_PORTS-1:0] egress_busy,
    output port_idx_t            grant,
    output port_idx_t            grant_target,
    output logic                 xfer,
    output logic [NUM_PORTS-1:0] pop,
    output logic                 busy,
    output dir_e                 direction
);

    arb_state_e state;
    port_idx_t  target_arr [NUM_PORTS];
    port_idx_t  pick;
    port_idx_t  pick_target;
    logic       pick_found;

    assign target_arr[0] = target_0;
    assign target_arr[1] = target_1;
    assign target_arr[2] = target_2;
    assign target_arr[3] = target_3;
    assign target_arr[4] = target_4;

    assign pick_target  = target_arr[pick];
    assign grant_target = target_arr[grant];   // Head is stable until popped

    // ****************************************
    // Round-robin search
    // ****************************************
    always_comb begin
        int cand;
        pick       = grant;
        pick_found = 1'b0;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            cand = (int'(grant) + i) % NUM_PORTS;   // Start after last grant
            if (!pick_found && not_empty[cand]) begin
                pick       = port_idx_t'(cand);
                pick_found = 1'b1;
            end
        end
    end

    // ****************************************
    // Grant FSM
    // ****************************************
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ARB_IDLE;
            grant <= PORT_GPU;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (arb_enable && pick_found) begin
                        grant <= pick;
                        state <= egress_busy[pick_target] ? ARB_HOLD : ARB_XFER;
                    end
                end
                ARB_HOLD: begin
                    if (!egress_busy[grant_target]) begin
                        state <= ARB_XFER;   // Grant kept, so no reordering
                    end
                end
                ARB_XFER: begin
                    state <= ARB_IDLE;
                end
                default: begin
                    state <= ARB_IDLE;
                end
            endcase
        end
    end

    assign xfer = (state == ARB_XFER);
    assign busy = (state != ARB_IDLE);
    assign pop  = xfer ? (NUM_PORTS'(1) << grant) : '0;

    always_comb begin
        direction = DIR_NONE;
        if (busy) begin
            if (grant == PORT_GPU && grant_target != PORT_GPU) begin
                direction = DIR_UP;
            end else if (grant != PORT_GPU && grant_target == PORT_GPU) begin
                direction = DIR_DOWN;
            end else if (grant != PORT_GPU) begin
                direction = DIR_TRANSIT;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        |pop |-> $onehot(pop) && ((pop & not_empty) == pop))
        else $error("crossbar_arbiter: bad pop vector %h", pop);

    // Switch must report the target register free on the transfer cycle
    assert property (@(posedge clk) disable iff (rst)
        xfer |-> !egress_busy[grant_target])
        else $error("crossbar_arbiter: xfer to busy port %0d", grant_target);

endmodule

// ==== source/crossbar_switch.sv ====
`timescale 1ns/1ns

module crossbar_switch
    import router_pkg::*;
#(
    parameter int DWIDTH = 16
)(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [DWIDTH-1:0]    head_data_0,
    input  logic [DWIDTH-1:0]    head_data_1,
    input  logic [DWIDTH-1:0]    head_data_2,
    input  logic [DWIDTH-1:0]    head_data_3,
    input  logic [DWIDTH-1:0]    head_data_4,
    input  port_idx_t            grant,
    input  port_idx_t            grant_target,
    input  logic                 xfer,
    output logic [DWIDTH-1:0]    out_data_0,
    output logic [DWIDTH-1:0]    out_data_1,
    output logic [DWIDTH-1:0]    out_data_2,
    output logic [DWIDTH-1:0]    out_data_3,
    output logic [DWIDTH-1:0]    out_data_4,
    output logic                 out_valid_0,
    output logic                 out_valid_1,
    output logic                 out_valid_2,
    output logic                 out_valid_3,
    output logic                 out_valid_4,
    input  logic                 out_ready_0,
    input  logic                 out_ready_1,
    input  logic                 out_ready_2,
    input  logic                 out_ready_3,
    input  logic                 out_ready_4,
    output logic [NUM_PORTS-1:0] egress_busy
);

    logic [DWIDTH-1:0]    head_arr    [NUM_PORTS];
    logic [DWIDTH-1:0]    egress_data [NUM_PORTS];
    logic [NUM_PORTS-1:0] egress_valid;
    logic [NUM_PORTS-1:0] ready_vec;
    logic [NUM_PORTS-1:0] load;
    logic [DWIDTH-1:0]    sel_data;

    assign head_arr[0] = head_data_0;
    assign head_arr[1] = head_data_1;
    assign head_arr[2] = head_data_2;
    assign head_arr[3] = head_data_3;
    assign head_arr[4] = head_data_4;

    assign ready_vec = {out_ready_4, out_ready_3, out_ready_2, out_ready_1, out_ready_0};

    assign sel_data    = head_arr[grant];
    assign load        = xfer ? (NUM_PORTS'(1) << grant_target) : '0;
    assign egress_busy = egress_valid & ~ready_vec;   // Free if drained this cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            egress_valid <= '0;
        end else begin
            egress_valid <= load | (egress_valid & ~ready_vec);
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (load[p]) begin
                egress_data[p] <= sel_data;
            end
        end
    end

    assign out_data_0  = egress_data[0];
    assign out_data_1  = egress_data[1];
    assign out_data_2  = egress_data[2];
    assign out_data_3  = egress_data[3];
    assign out_data_4  = egress_data[4];
    assign out_valid_0 = egress_valid[0];
    assign out_valid_1 = egress_valid[1];
    assign out_valid_2 = egress_valid[2];
    assign out_valid_3 = egress_valid[3];
    assign out_valid_4 = egress_valid[4];

    // A held word is never overwritten or dropped before its handshake
    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_hold_chk
        assert property (@(posedge clk) disable iff (rst)
            egress_valid[p] && !ready_vec[p] |=> egress_valid[p] && $stable(egress_data[p]))
            else $error("crossbar_switch: egress %0d changed while held", p);
    end

endmodule

// ==== source/enhanced_router.sv ====
`timescale 1ns/1ns

module enhanced_router
    import router_pkg::*;
#(
    parameter int ROUTER_ID  = 3,
    parameter int DWIDTH     = 16,
    parameter int FIFO_DEPTH = 8,
    parameter int GROUP_ID   = 4'b0100
)(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 arb_enable,

    input  logic [DWIDTH-1:0]    gpu_in_data,
    input  logic                 gpu_in_valid,
    input  addr_t                gpu_dest_addr,
    output logic                 gpu_in_ready,
    output logic [DWIDTH-1:0]    gpu_out_data,
    output logic                 gpu_out_valid,
    input  logic                 gpu_out_ready,

    input  logic [DWIDTH-1:0]    spine1_in_data,
    input  logic                 spine1_in_valid,
    input  addr_t                spine1_dest_addr,
    output logic                 spine1_in_ready,
    output logic [DWIDTH-1:0]    spine1_out_data,
    output logic                 spine1_out_valid,
    input  logic                 spine1_out_ready,

    input  logic [DWIDTH-1:0]    spine2_in_data,
    input  logic                 spine2_in_valid,
    input  addr_t                spine2_dest_addr,
    output logic                 spine2_in_ready,
    output logic [DWIDTH-1:0]    spine2_out_data,
    output logic                 spine2_out_valid,
    input  logic                 spine2_out_ready,

    input  logic [DWIDTH-1:0]    spine3_in_data,
    input  logic                 spine3_in_valid,
    input  addr_t                spine3_dest_addr,
    output logic                 spine3_in_ready,
    output logic [DWIDTH-1:0]    spine3_out_data,
    output logic                 spine3_out_valid,
    input  logic                 spine3_out_ready,

    input  logic [DWIDTH-1:0]    spine4_in_data,
    input  logic                 spine4_in_valid,
    input  addr_t                spine4_dest_addr,
    output logic                 spine4_in_ready,
    output logic [DWIDTH-1:0]    spine4_out_data,
    output logic                 spine4_out_valid,
    input  logic                 spine4_out_ready,

    output logic [NUM_PORTS-1:0] fifo_in_full,
    output logic [NUM_PORTS-1:0] fifo_in_empty,
    output logic                 crossbar_busy,
    output port_idx_t            current_grant,
    output dir_e                 routing_direction
);

    logic [DWIDTH-1:0]    in_data   [NUM_PORTS];
    addr_t                dest_addr [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_valid;
    logic [NUM_PORTS-1:0] in_ready;
    logic [DWIDTH-1:0]    head_data [NUM_PORTS];
    addr_t                head_addr [NUM_PORTS];
    port_idx_t            target    [NUM_PORTS];
    logic [NUM_PORTS-1:0] pop;
    logic [NUM_PORTS-1:0] egress_busy;
    port_idx_t            grant_target;
    logic                 xfer;

    // ****************************************
    // Ingress port mapping
    // ****************************************
    assign in_data[PORT_GPU]      = gpu_in_data;
    assign in_data[PORT_SPINE1]   = spine1_in_data;
    assign in_data[PORT_SPINE2]   = spine2_in_data;
    assign in_data[PORT_SPINE3]   = spine3_in_data;
    assign in_data[PORT_SPINE4]   = spine4_in_data;
    assign dest_addr[PORT_GPU]    = gpu_dest_addr;
    assign dest_addr[PORT_SPINE1] = spine1_dest_addr;
    assign dest_addr[PORT_SPINE2] = spine2_dest_addr;
    assign dest_addr[PORT_SPINE3] = spine3_dest_addr;
    assign dest_addr[PORT_SPINE4] = spine4_dest_addr;

    assign in_valid = {spine4_in_valid, spine3_in_valid, spine2_in_valid,
                       spine1_in_valid, gpu_in_valid};

    assign gpu_in_ready    = in_ready[PORT_GPU];
    assign spine1_in_ready = in_ready[PORT_SPINE1];
    assign spine2_in_ready = in_ready[PORT_SPINE2];
    assign spine3_in_ready = in_ready[PORT_SPINE3];
    assign spine4_in_ready = in_ready[PORT_SPINE4];

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        port_fifo #(
            .DWIDTH(DWIDTH),
            .FIFO_DEPTH(FIFO_DEPTH)
        ) fifo_inst (
            .clk(clk),
            .rst(rst),
            .in_data(in_data[i]),
            .in_valid(in_valid[i]),
            .dest_addr(dest_addr[i]),
            .in_ready(in_ready[i]),
            .pop(pop[i]),
            .head_data(head_data[i]),
            .head_addr(head_addr[i]),
            .empty(fifo_in_empty[i]),
            .full(fifo_in_full[i])
        );

        route_decoder #(
            .GROUP_ID(GROUP_ID),
            .ROUTER_ID(ROUTER_ID)
        ) decoder_inst (
            .head_addr(head_addr[i]),
            .target(target[i])
        );
    end

    // ****************************************
    // Crossbar control and datapath
    // ****************************************
    crossbar_arbiter arbiter_inst (
        .clk(clk),
        .rst(rst),
        .arb_enable(arb_enable),
        .not_empty(~fifo_in_empty),
        .target_0(target[0]),
        .target_1(target[1]),
        .target_2(target[2]),
        .target_3(target[3]),
        .target_4(target[4]),
        .egress_busy(egress_busy),
        .grant(current_grant),
        .grant_target(grant_target),
        .xfer(xfer),
        .pop(pop),
        .busy(crossbar_busy),
        .direction(routing_direction)
    );

    crossbar_switch #(
        .DWIDTH(DWIDTH)
    ) switch_inst (
        .clk(clk),
        .rst(rst),
        .head_data_0(head_data[0]),
        .head_data_1(head_data[1]),
        .head_data_2(head_data[2]),
        .head_data_3(head_data[3]),
        .head_data_4(head_data[4]),
        .grant(current_grant),
        .grant_target(grant_target),
        .xfer(xfer),
        .out_data_0(gpu_out_data),
        .out_data_1(spine1_out_data),
        .out_data_2(spine2_out_data),
        .out_data_3(spine3_out_data),
        .out_data_4(spine4_out_data),
        .out_valid_0(gpu_out_valid),
        .out_valid_1(spine1_out_valid),
        .out_valid_2(spine2_out_valid),
        .out_valid_3(spine3_out_valid),
        .out_valid_4(spine4_out_valid),
        .out_ready_0(gpu_out_ready),
        .out_ready_1(spine1_out_ready),
        .out_ready_2(spine2_out_ready),
        .out_ready_3(spine3_out_ready),
        .out_ready_4(spine4_out_ready),
        .egress_busy(egress_busy)
    );

endmodule

// ==== sim/tb_enhanced_router.sv ====
`timescale 1ns/1ns

module tb_enhanced_router
    import router_pkg::*;
();

    localparam int DWIDTH     = 16;
    localparam int FIFO_DEPTH = 8;
    localparam int GROUP_ID   = 4'b0100;
    localparam int ROUTER_ID  = 3;
    localparam int TIMEOUT    = 2000;   // Cycles allowed per wait
    localparam int MAX_PKT    = 64;

    logic                 clk;
    logic                 rst;
    logic                 arb_enable;
    logic [DWIDTH-1:0]    in_data   [NUM_PORTS];
    addr_t                dest_addr [NUM_PORTS];
    logic [NUM_PORTS-1:0] in_valid;
    logic [NUM_PORTS-1:0] in_ready;
    logic [DWIDTH-1:0]    out_data  [NUM_PORTS];
    logic [NUM_PORTS-1:0] out_valid;
    logic [NUM_PORTS-1:0] out_ready;
    logic [NUM_PORTS-1:0] fifo_in_full;
    logic [NUM_PORTS-1:0] fifo_in_empty;
    logic                 crossbar_busy;
    port_idx_t            current_grant;
    dir_e                 routing_direction;

    logic [DWIDTH-1:0]    exp_q   [NUM_PORTS*NUM_PORTS][$];   // Index src*NUM_PORTS + dst
    int                   route_q [NUM_PORTS][$];             // Targets queued per source
    logic [NUM_PORTS-1:0] hold_low;
    logic [NUM_PORTS-1:0] held;
    logic [DWIDTH-1:0]    held_data [NUM_PORTS];
    logic                 busy_d;
    port_idx_t            grant_d;
    int                   errors;
    int                   sent;
    int                   received;
    int                   seed;

    int                   n_pkt;
    int                   pk_phase [MAX_PKT];
    int                   pk_src   [MAX_PKT];
    addr_t                pk_addr  [MAX_PKT];
    logic [DWIDTH-1:0]    pk_data  [MAX_PKT];

    enhanced_router #(
        .ROUTER_ID(ROUTER_ID),
        .DWIDTH(DWIDTH),
        .FIFO_DEPTH(FIFO_DEPTH),
        .GROUP_ID(GROUP_ID)
    ) enhanced_router_inst (
        .clk(clk),
        .rst(rst),
        .arb_enable(arb_enable),
        .gpu_in_data(in_data[0]),
        .gpu_in_valid(in_valid[0]),
        .gpu_dest_addr(dest_addr[0]),
        .gpu_in_ready(in_ready[0]),
        .gpu_out_data(out_data[0]),
        .gpu_out_valid(out_valid[0]),
        .gpu_out_ready(out_ready[0]),
        .spine1_in_data(in_data[1]),
        .spine1_in_valid(in_valid[1]),
        .spine1_dest_addr(dest_addr[1]),
        .spine1_in_ready(in_ready[1]),
        .spine1_out_data(out_data[1]),
        .spine1_out_valid(out_valid[1]),
        .spine1_out_ready(out_ready[1]),
        .spine2_in_data(in_data[2]),
        .spine2_in_valid(in_valid[2]),
        .spine2_dest_addr(dest_addr[2]),
        .spine2_in_ready(in_ready[2]),
        .spine2_out_data(out_data[2]),
        .spine2_out_valid(out_valid[2]),
        .spine2_out_ready(out_ready[2]),
        .spine3_in_data(in_data[3]),
        .spine3_in_valid(in_valid[3]),
        .spine3_dest_addr(dest_addr[3]),
        .spine3_in_ready(in_ready[3]),
        .spine3_out_data(out_data[3]),
        .spine3_out_valid(out_valid[3]),
        .spine3_out_ready(out_ready[3]),
        .spine4_in_data(in_data[4]),
        .spine4_in_valid(in_valid[4]),
        .spine4_dest_addr(dest_addr[4]),
        .spine4_in_ready(in_ready[4]),
        .spine4_out_data(out_data[4]),
        .spine4_out_valid(out_valid[4]),
        .spine4_out_ready(out_ready[4]),
        .fifo_in_full(fifo_in_full),
        .fifo_in_empty(fifo_in_empty),
        .crossbar_busy(crossbar_busy),
        .current_grant(current_grant),
        .routing_direction(routing_direction)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ****************************************
    // Reference model
    // ****************************************
    function automatic int expected_port(input addr_t addr);
        if (addr[5:2] == GROUP_ID[3:0] && addr[1:0] == ROUTER_ID[1:0]) begin
            return 0;   // Local GPU
        end
        return int'(addr[1:0]) + 1;
    endfunction

    function automatic dir_e expected_dir(input int src, input int dst);
        if (src == 0 && dst != 0) return DIR_UP;
        if (src != 0 && dst == 0) return DIR_DOWN;
        if (src != 0) return DIR_TRANSIT;
        return DIR_NONE;
    endfunction

    function automatic int pending_count();
        int total;
        total = 0;
        for (int i = 0; i < NUM_PORTS*NUM_PORTS; i++) total += exp_q[i].size();
        for (int s = 0; s < NUM_PORTS; s++) total += route_q[s].size();
        return total;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        errors++;
        $display("Error %s: got %0h, expected %0h at %0t", name, got, want, $time);
    endtask

    task automatic report_fail(input string msg);
        errors++;
        $display("%s at %0t", msg, $time);
    endtask

    // ****************************************
    // Stimulus
    // ****************************************
    task automatic load_stim();
        int          fd;
        int          code;
        int          ph;
        int          src;
        int          port;
        logic [31:0] addr_v;
        logic [31:0] data_v;
        string       line;
        n_pkt = 0;
        fd = $fopen("sim/router_stim.txt", "r");
        if (fd == 0) begin
            report_fail("Could not open the stimulus file sim/router_stim.txt");
            return;
        end
        while (!$feof(fd) && n_pkt < MAX_PKT) begin
            void'($fgets(line, fd));
            code = $sscanf(line, "%d %d %h %h %d", ph, src, addr_v, data_v, port);
            if (code == 5) begin
                pk_phase[n_pkt] = ph;
                pk_src[n_pkt]   = src;
                pk_addr[n_pkt]  = addr_v[5:0];
                pk_data[n_pkt]  = data_v[DWIDTH-1:0];
                assert (port == expected_port(addr_v[5:0]))
                    else report_fail($sformatf("Stim line %0d lists port %0d against the rule",
                                               n_pkt, port));
                n_pkt++;
            end
        end
        $fclose(fd);
    endtask

    // Called and returns 1 ns after a rising edge
    task automatic send_word(input int src, input addr_t addr, input logic [DWIDTH-1:0] data);
        int waited;
        exp_q[src*NUM_PORTS + expected_port(addr)].push_back(data);
        route_q[src].push_back(expected_port(addr));
        in_data[src]   = data;
        dest_addr[src] = addr;
        in_valid[src]  = 1'b1;
        waited = 0;
        while (!in_ready[src] && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (waited < TIMEOUT)
            else report_fail($sformatf("Timeout: port %0d never accepted word %h", src, data));
        @(posedge clk);
        #1;
        in_valid[src] = 1'b0;
        sent++;
    endtask

    task automatic send_burst(input int src, input addr_t addr, input logic [DWIDTH-1:0] base);
        int dst;
        int waited;
        dst = expected_port(addr);
        hold_low[dst] = 1'b1;
        for (int i = 0; i <= FIFO_DEPTH; i++) begin
            send_word(src, addr, base + DWIDTH'(i));
        end
        waited = 0;
        while (!fifo_in_full[src] && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (fifo_in_full[src])
            else report_value($sformatf("fifo_in_full[%0d]", src),
                              32'(fifo_in_full[src]), 32'h1);
        assert (!in_ready[src])
            else report_value($sformatf("in_ready[%0d]", src),
                              32'(in_ready[src]), 32'h0);
        hold_low[dst] = 1'b0;
        send_word(src, addr, base + DWIDTH'(FIFO_DEPTH + 1));   // Waits for space
    endtask

    task automatic wait_drain(input string what);
        int waited;
        waited = 0;
        while ((pending_count() > 0 || fifo_in_empty != '1 || crossbar_busy)
               && waited < TIMEOUT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (waited < TIMEOUT)
            else report_fail($sformatf("Timeout: %s traffic did not drain", what));
    endtask

    always @(posedge clk) begin : drive_ready
        logic [NUM_PORTS-1:0] hold_now;
        int                   rnd;
        hold_now = hold_low;   // Taken at the edge, applied 1 ns later
        #1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            rnd = $random(seed);
            out_ready[p] = hold_now[p] ? 1'b0 : rnd[0];
        end
    end

    // ****************************************
    // Output and status monitor
    // ****************************************
    always @(posedge clk) begin : check_outputs
        int   idx;
        logic found;
        if (!rst) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (held[p]) begin
                    assert (out_valid[p])
                        else report_fail($sformatf("Port %0d dropped out_valid before ready", p));
                    assert (out_data[p] == held_data[p])
                        else report_value($sformatf("out_data[%0d]", p), 32'(out_data[p]),
                                          32'(held_data[p]));
                end
                if (out_valid[p] && out_ready[p]) begin
                    found = 1'b0;
                    for (int s = 0; s < NUM_PORTS; s++) begin
                        idx = s*NUM_PORTS + p;
                        if (!found && exp_q[idx].size() > 0 && exp_q[idx][0] == out_data[p]) begin
                            void'(exp_q[idx].pop_front());
                            found = 1'b1;
                            received++;
                        end
                    end
                    assert (found)
                        else report_fail($sformatf("Port %0d delivered word %h out of order",
                                                   p, out_data[p]));
                end
                held[p]      = out_valid[p] && !out_ready[p];
                held_data[p] = out_data[p];
            end
            if (crossbar_busy) begin
                assert (route_q[current_grant].size() > 0)
                    else report_fail($sformatf("Grant to port %0d with nothing queued",
                                               current_grant));
                if (route_q[current_grant].size() > 0) begin
                    assert (routing_direction ==
                            expected_dir(int'(current_grant), route_q[current_grant][0]))
                        else report_value("routing_direction", 32'(routing_direction),
                            32'(expected_dir(int'(current_grant), route_q[current_grant][0])));
                end
                if (busy_d) begin
                    assert (current_grant == grant_d)
                        else report_value("current_grant", 32'(current_grant), 32'(grant_d));
                end
            end else if (busy_d && route_q[grant_d].size() > 0) begin
                void'(route_q[grant_d].pop_front());   // One busy period per packet
            end
            busy_d  = crossbar_busy;
            grant_d = current_grant;
        end
    end

    // ****************************************
    // Test sequence
    // ****************************************
    initial begin
        rst        = 1'b1;
        arb_enable = 1'b1;
        in_valid   = '0;
        out_ready  = '0;
        hold_low   = '0;
        held       = '0;
        busy_d     = 1'b0;
        grant_d    = '0;
        errors     = 0;
        sent       = 0;
        received   = 0;
        seed       = 32'h7482_9a56;
        for (int p = 0; p < NUM_PORTS; p++) begin
            in_data[p]   = '0;
            dest_addr[p] = '0;
            held_data[p] = '0;
        end
        load_stim();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        assert (out_valid == '0) else report_value("out_valid", 32'(out_valid), 32'h0);
        assert (!crossbar_busy) else report_value("crossbar_busy", 32'(crossbar_busy), 32'h0);
        assert (current_grant == PORT_GPU)
            else report_value("current_grant", 32'(current_grant), 32'h0);
        assert (routing_direction == DIR_NONE)
            else report_value("routing_direction", 32'(routing_direction), 32'(DIR_NONE));
        assert (in_ready == '1) else report_value("in_ready", 32'(in_ready), 32'h1f);
        assert (fifo_in_empty == '1)
            else report_value("fifo_in_empty", 32'(fifo_in_empty), 32'h1f);

        for (int i = 0; i < n_pkt; i++) begin
            if (pk_phase[i] == 1) send_word(pk_src[i], pk_addr[i], pk_data[i]);
        end
        wait_drain("routed");

        for (int i = 0; i < n_pkt; i++) begin
            if (pk_phase[i] == 2) send_burst(pk_src[i], pk_addr[i], pk_data[i]);
        end
        wait_drain("burst");

        arb_enable = 1'b0;
        for (int i = 0; i < n_pkt; i++) begin
            if (pk_phase[i] == 3) send_word(pk_src[i], pk_addr[i], pk_data[i]);
        end
        repeat (20) begin
            @(posedge clk);
            #1;
            assert (out_valid == '0) else report_value("out_valid", 32'(out_valid), 32'h0);
            assert (!crossbar_busy)
                else report_value("crossbar_busy", 32'(crossbar_busy), 32'h0);
        end
        arb_enable = 1'b1;
        wait_drain("held back");

        assert (received == sent)
            else report_fail($sformatf("%0d words sent but %0d received", sent, received));
        $display("Summary: %0d errors, %0d words sent, %0d words received",
                 errors, sent, received);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sim/router_stim.txt ====
# Columns: phase src_port dest_addr(hex) data(hex) expected_port
# Phase 1 single words, 2 burst of FIFO_DEPTH+2 from data upward, 3 sent with arbitration off
1 0 10 a001 1
1 0 21 a002 2
1 1 13 a003 0
1 2 13 a004 0
1 3 07 a005 4
1 4 3e a006 3
1 0 12 a007 3
1 2 21 a008 2
1 4 13 a009 0
1 1 10 a00a 1
1 3 13 a00b 0
1 0 07 a00c 4
2 2 12 b000 3
3 3 13 c001 0
3 0 07 c002 4
3 4 21 c003 2
3 1 3e c004 3

// ==== src.f ====
source/router_pkg.sv
source/port_fifo.sv
source/route_decoder.sv
source/crossbar_arbiter.sv
source/crossbar_switch.sv
source/enhanced_router.sv
sim/tb_enhanced_router.sv

// ==== Makefile ====
# Verilator build and run of the router testbench

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module tb_enhanced_router -o Vtb_enhanced_router
	./obj_dir/Vtb_enhanced_router > sim.log 2>&1 ; cat sim.log
	grep -qx "=== PASS ===" sim.log

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module tb_enhanced_router

clean:
	rm -rf obj_dir sim.log
